// ==== hdl/dps_pkg.sv ====
package dps_pkg;

	// Region bases
	// Address bits above the low byte pick the block
	localparam logic [31:0] TIMER_BASE = 32'h0000_0000;
	localparam logic [31:0] SCI_BASE   = 32'h0000_0100;

	// Timer register offsets
	localparam logic [3:0] TIMER_CTRL  = 4'h0;
	localparam logic [3:0] TIMER_COUNT = 4'h4;
	localparam logic [3:0] TIMER_CMP   = 4'h8;
	localparam logic [3:0] TIMER_MODE  = 4'hC;

	// UART register offsets
	localparam logic [3:0] SCI_TXD  = 4'h0;
	localparam logic [3:0] SCI_RXD  = 4'h4;
	localparam logic [3:0] SCI_CFG  = 4'h8;
	localparam logic [3:0] SCI_STAT = 4'hC;

	// Interrupt sources in the 64-entry table
	localparam logic [5:0] IRQ_NUM_TIMER  = 6'd36;
	localparam logic [5:0] IRQ_NUM_SCI_RX = 6'd37;

	// Clock cycles per UART bit
	localparam int BAUD_DIV = 16;
	localparam int BAUD_W   = $clog2(BAUD_DIV);
	// Last cycle of a bit period
	localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(BAUD_DIV - 1);
	// Start bit middle, counted from the falling edge
	localparam logic [BAUD_W-1:0] BAUD_HALF = BAUD_W'(BAUD_DIV / 2 - 1);

	// Bus request sequence
	typedef enum logic [1:0] {
		BUS_IDLE,
		BUS_ACCESS,
		BUS_RESPOND
	} bus_state_t;

	// Shared by UART transmit and receive
	typedef enum logic [1:0] {
		SCI_IDLE,
		SCI_START,
		SCI_DATA,
		SCI_STOP
	} sci_state_t;

endpackage

// ==== hdl/dps_reg_if.sv ====
interface dps_reg_if;

	// Select, one cycle per access
	logic        sel;
	logic        we;
	// Word offset inside the block
	logic [3:0]  offset;
	logic [31:0] wdata;
	// Registered by the block on the select cycle
	logic [31:0] rdata;

	// Bus control side
	modport master (output sel, output we, output offset, output wdata, input rdata);

	// Peripheral side
	modport slave (input sel, input we, input offset, input wdata, output rdata);

endinterface

// ==== hdl/dps_bus_ctrl.sv ====
module dps_bus_ctrl (
	input  logic        clock,
	input  logic        rst,
	input  logic        req,
	input  logic        rw,
	input  logic [31:0] addr,
	input  logic [31:0] wdata,
	output logic        busy,
	output logic        valid,
	output logic [31:0] rdata,
	dps_reg_if.master   timer_bus,
	dps_reg_if.master   sci_bus
);

	dps_pkg::bus_state_t state;

	// Latched request
	logic        rw_q;
	logic [3:0]  offset_q;
	logic [31:0] wdata_q;
	logic        timer_hit_q;
	logic        sci_hit_q;

	// High in the first ACCESS cycle only
	logic        first_cycle;
	logic        accept;
	logic        timer_hit;
	logic        sci_hit;

	// Busy only while the access is in flight
	assign busy   = (state == dps_pkg::BUS_ACCESS);
	assign accept = req && !busy;

	// Region decode on the upper address bits
	assign timer_hit = (addr[31:8] == dps_pkg::TIMER_BASE[31:8]);
	assign sci_hit   = (addr[31:8] == dps_pkg::SCI_BASE[31:8]);

	// IDLE -> ACCESS (two cycles) -> RESPOND
	always_ff @(posedge clock) begin
		if (rst) begin
			state       <= dps_pkg::BUS_IDLE;
			first_cycle <= 1'b0;
		end else begin
			case (state)
				dps_pkg::BUS_ACCESS: begin
					// Second cycle waits for the registered read data
					if (first_cycle) begin
						first_cycle <= 1'b0;
					end else begin
						state <= dps_pkg::BUS_RESPOND;
					end
				end
				default: begin
					// RESPOND is not busy, so a new request may follow at once
					if (accept) begin
						state       <= dps_pkg::BUS_ACCESS;
						first_cycle <= 1'b1;
					end else begin
						state <= dps_pkg::BUS_IDLE;
					end
				end
			endcase
		end
	end

	// Capture request fields and region once
	always_ff @(posedge clock) begin
		if (accept) begin
			rw_q        <= rw;
			offset_q    <= addr[3:0];
			wdata_q     <= wdata;
			timer_hit_q <= timer_hit;
			sci_hit_q   <= sci_hit;
		end
	end

	// Single select pulse to the decoded block
	assign timer_bus.sel    = (state == dps_pkg::BUS_ACCESS) && first_cycle && timer_hit_q;
	assign timer_bus.we     = rw_q;
	assign timer_bus.offset = offset_q;
	assign timer_bus.wdata  = wdata_q;

	assign sci_bus.sel    = (state == dps_pkg::BUS_ACCESS) && first_cycle && sci_hit_q;
	assign sci_bus.we     = rw_q;
	assign sci_bus.offset = offset_q;
	assign sci_bus.wdata  = wdata_q;

	// Valid pulse for reads only
	assign valid = (state == dps_pkg::BUS_RESPOND) && !rw_q;

	// Unmapped region reads as zero
	assign rdata = timer_hit_q ? timer_bus.rdata :
		sci_hit_q ? sci_bus.rdata : 32'h0;

endmodule

// ==== hdl/dps_timer.sv ====
module dps_timer (
	input  logic     clock,
	input  logic     rst,
	dps_reg_if.slave bus,
	output logic     match
);

	logic        run;
	logic [31:0] count;
	logic [31:0] cmp;
	// bit 0 interrupt enable, bit 1 periodic
	logic [1:0]  mode;
	logic        hit;
	logic        wr;

	assign wr  = bus.sel && bus.we;
	// Compare only counts while running
	assign hit = run && (count == cmp);

	always_ff @(posedge clock) begin
		if (rst) begin
			run   <= 1'b0;
			count <= '0;
			mode  <= '0;
			match <= 1'b0;
		end else begin
			// Event pulse only with interrupts on
			match <= hit && mode[0];
			if (hit) begin
				// Periodic reloads, one-shot stops
				if (mode[1]) begin
					count <= '0;
				end else begin
					run <= 1'b0;
				end
			end else if (run) begin
				count <= count + 32'd1;
			end
			// Start restarts from zero
			if (wr && bus.offset == dps_pkg::TIMER_CTRL) begin
				run <= bus.wdata[0];
				if (bus.wdata[0]) begin
					count <= '0;
				end
			end
			if (wr && bus.offset == dps_pkg::TIMER_MODE) begin
				mode <= bus.wdata[1:0];
			end
		end
	end

	// Compare value
	always_ff @(posedge clock) begin
		if (wr && bus.offset == dps_pkg::TIMER_CMP) begin
			cmp <= bus.wdata;
		end
	end

	// Read data registered on select
	always_ff @(posedge clock) begin
		if (bus.sel) begin
			case (bus.offset)
				dps_pkg::TIMER_CTRL:  bus.rdata <= {31'b0, run};
				dps_pkg::TIMER_COUNT: bus.rdata <= count;
				dps_pkg::TIMER_CMP:   bus.rdata <= cmp;
				dps_pkg::TIMER_MODE:  bus.rdata <= {30'b0, mode};
				default:              bus.rdata <= '0;
			endcase
		end
	end

endmodule

// ==== hdl/dps_sci.sv ====
module dps_sci (
	input  logic     clock,
	input  logic     rst,
	input  logic     rxd,
	dps_reg_if.slave bus,
	output logic     txd,
	output logic     rx_event
);

	dps_pkg::sci_state_t tx_state;
	dps_pkg::sci_state_t rx_state;

	// bit 0 enable, bit 1 receive interrupt
	logic [31:0]                cfg;
	logic [7:0]                 tx_shift;
	logic [2:0]                 tx_bit;
	logic [dps_pkg::BAUD_W-1:0] tx_cnt;
	logic                       tx_tick;
	logic                       tx_busy;
	logic                       tx_start;
	logic [7:0]                 rx_shift;
	logic [7:0]                 rx_data;
	logic [2:0]                 rx_bit;
	logic [dps_pkg::BAUD_W-1:0] rx_cnt;
	logic                       rx_tick;
	logic                       rx_take;
	logic                       rx_full;
	logic                       rxd_meta;
	logic                       rxd_sync;
	logic                       wr;
	logic                       rd_rxd;

	assign wr       = bus.sel && bus.we;
	assign rd_rxd   = bus.sel && !bus.we && (bus.offset == dps_pkg::SCI_RXD);
	assign tx_busy  = (tx_state != dps_pkg::SCI_IDLE);
	// Writes while a frame is out are dropped
	assign tx_start = wr && (bus.offset == dps_pkg::SCI_TXD) && cfg[0] && !tx_busy;

	// Configuration
	always_ff @(posedge clock) begin
		if (rst) begin
			cfg <= '0;
		end else if (wr && bus.offset == dps_pkg::SCI_CFG) begin
			cfg <= bus.wdata;
		end
	end

	// Transmit bit timing
	assign tx_tick = (tx_cnt == dps_pkg::BAUD_LAST);

	always_ff @(posedge clock) begin
		if (rst) begin
			tx_state <= dps_pkg::SCI_IDLE;
			tx_cnt   <= '0;
			tx_bit   <= '0;
		end else begin
			if (tx_state == dps_pkg::SCI_IDLE || tx_tick) begin
				tx_cnt <= '0;
			end else begin
				tx_cnt <= tx_cnt + 1'b1;
			end
			case (tx_state)
				dps_pkg::SCI_IDLE: begin
					if (tx_start) begin
						tx_state <= dps_pkg::SCI_START;
					end
				end
				dps_pkg::SCI_START: begin
					if (tx_tick) begin
						tx_state <= dps_pkg::SCI_DATA;
						tx_bit   <= '0;
					end
				end
				dps_pkg::SCI_DATA: begin
					if (tx_tick) begin
						tx_bit <= tx_bit + 1'b1;
						// Eight data bits, LSB first
						if (tx_bit == 3'd7) begin
							tx_state <= dps_pkg::SCI_STOP;
						end
					end
				end
				default: begin
					if (tx_tick) begin
						tx_state <= dps_pkg::SCI_IDLE;
					end
				end
			endcase
		end
	end

	// Byte being sent
	always_ff @(posedge clock) begin
		if (tx_start) begin
			tx_shift <= bus.wdata[7:0];
		end else if (tx_state == dps_pkg::SCI_DATA && tx_tick) begin
			tx_shift <= {1'b0, tx_shift[7:1]};
		end
	end

	// Line idles high
	assign txd = (tx_state == dps_pkg::SCI_START) ? 1'b0 :
		(tx_state == dps_pkg::SCI_DATA) ? tx_shift[0] : 1'b1;

	// Two-flop input synchronizer
	always_ff @(posedge clock) begin
		if (rst) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
		end
	end

	// Half a bit into the start bit, then whole bits
	assign rx_tick = (rx_state == dps_pkg::SCI_START) ? (rx_cnt == dps_pkg::BAUD_HALF) :
		(rx_cnt == dps_pkg::BAUD_LAST);
	assign rx_take = (rx_state == dps_pkg::SCI_STOP) && rx_tick;

	always_ff @(posedge clock) begin
		if (rst) begin
			rx_state <= dps_pkg::SCI_IDLE;
			rx_cnt   <= '0;
			rx_bit   <= '0;
			rx_full  <= 1'b0;
			rx_event <= 1'b0;
		end else begin
			if (rx_state == dps_pkg::SCI_IDLE || rx_tick) begin
				rx_cnt <= '0;
			end else begin
				rx_cnt <= rx_cnt + 1'b1;
			end
			case (rx_state)
				dps_pkg::SCI_IDLE: begin
					if (cfg[0] && !rxd_sync) begin
						rx_state <= dps_pkg::SCI_START;
					end
				end
				dps_pkg::SCI_START: begin
					// Line back high at mid start means a glitch
					if (rx_tick) begin
						rx_state <= rxd_sync ? dps_pkg::SCI_IDLE : dps_pkg::SCI_DATA;
						rx_bit   <= '0;
					end
				end
				dps_pkg::SCI_DATA: begin
					if (rx_tick) begin
						rx_bit <= rx_bit + 1'b1;
						if (rx_bit == 3'd7) begin
							rx_state <= dps_pkg::SCI_STOP;
						end
					end
				end
				default: begin
					if (rx_tick) begin
						rx_state <= dps_pkg::SCI_IDLE;
					end
				end
			endcase
			// New byte wins over a clearing read
			if (rx_take) begin
				rx_full <= 1'b1;
			end else if (rd_rxd) begin
				rx_full <= 1'b0;
			end
			rx_event <= rx_take && cfg[1];
		end
	end

	// Received byte
	always_ff @(posedge clock) begin
		if (rx_state == dps_pkg::SCI_DATA && rx_tick) begin
			rx_shift <= {rxd_sync, rx_shift[7:1]};
		end
		if (rx_take) begin
			rx_data <= rx_shift;
		end
	end

	// Read data registered on select
	always_ff @(posedge clock) begin
		if (bus.sel) begin
			case (bus.offset)
				dps_pkg::SCI_RXD:  bus.rdata <= {24'b0, rx_data};
				dps_pkg::SCI_CFG:  bus.rdata <= cfg;
				dps_pkg::SCI_STAT: bus.rdata <= {30'b0, rx_full, tx_busy};
				default:           bus.rdata <= '0;
			endcase
		end
	end

endmodule

// ==== hdl/dps_irq_ctrl.sv ====
module dps_irq_ctrl (
	input  logic        clock,
	input  logic        rst,
	input  logic        cfg_req,
	input  logic [5:0]  cfg_entry,
	input  logic        cfg_valid,
	input  logic        cfg_mask,
	input  logic [1:0]  cfg_level,
	input  logic [63:0] events,
	input  logic        ack,
	output logic        irq_req,
	output logic [5:0]  irq_num
);

	// Configuration table
	logic [63:0] ent_valid;
	logic [63:0] ent_mask;
	logic [1:0]  ent_level [64];

	logic [63:0] pending;
	logic [63:0] enabled;
	logic [63:0] served;
	logic        found;
	logic [5:0]  best_num;
	logic [1:0]  best_level;

	// Entry takes part only when valid and unmasked
	assign enabled = ent_valid & ent_mask;
	// Pending bit of the acknowledged request
	assign served  = (irq_req && ack) ? (64'd1 << irq_num) : '0;

	// Valid and mask flags
	always_ff @(posedge clock) begin
		if (rst) begin
			ent_valid <= '0;
			ent_mask  <= '0;
		end else if (cfg_req) begin
			ent_valid[cfg_entry] <= cfg_valid;
			ent_mask[cfg_entry]  <= cfg_mask;
		end
	end

	// Levels
	always_ff @(posedge clock) begin
		if (cfg_req) begin
			ent_level[cfg_entry] <= cfg_level;
		end
	end

	// Highest level wins
	// Scan downward so ties end on the lower number
	always_comb begin
		found      = 1'b0;
		best_num   = '0;
		best_level = '0;
		for (int i = 63; i >= 0; i--) begin
			if (pending[i] && enabled[i] && (!found || ent_level[i] >= best_level)) begin
				found      = 1'b1;
				best_num   = 6'(i);
				best_level = ent_level[i];
			end
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			pending <= '0;
			irq_req <= 1'b0;
			irq_num <= '0;
		end else begin
			// Disabled entries keep their pending bits
			pending <= (pending & ~served) | events;
			if (irq_req) begin
				// Hold number until acknowledge
				if (ack) begin
					irq_req <= 1'b0;
				end
			end else if (found) begin
				irq_req <= 1'b1;
				irq_num <= best_num;
			end
		end
	end

endmodule

// ==== hdl/default_peripheral_system.sv ====
module default_peripheral_system (
	input  logic        clock,
	input  logic        rst,
	// Interrupt table configuration
	input  logic        irq_cfg_req,
	input  logic [5:0]  irq_cfg_entry,
	input  logic        irq_cfg_valid,
	input  logic        irq_cfg_mask,
	input  logic [1:0]  irq_cfg_level,
	// Register bus, rw high for write
	input  logic        req,
	input  logic        rw,
	input  logic [31:0] addr,
	input  logic [31:0] wdata,
	output logic        busy,
	output logic        valid,
	output logic [31:0] rdata,
	// Interrupt request
	output logic        irq_req,
	output logic [5:0]  irq_num,
	input  logic        irq_ack,
	// UART line
	output logic        sci_txd,
	input  logic        sci_rxd
);

	logic        timer_match;
	logic        sci_rx_event;
	logic [63:0] irq_events;

	dps_reg_if timer_bus ();
	dps_reg_if sci_bus ();

	// Source events into their table slots
	always_comb begin
		irq_events                          = '0;
		irq_events[dps_pkg::IRQ_NUM_TIMER]  = timer_match;
		irq_events[dps_pkg::IRQ_NUM_SCI_RX] = sci_rx_event;
	end

	dps_bus_ctrl bus_ctrl_i (
		.clock     (clock),
		.rst       (rst),
		.req       (req),
		.rw        (rw),
		.addr      (addr),
		.wdata     (wdata),
		.busy      (busy),
		.valid     (valid),
		.rdata     (rdata),
		.timer_bus (timer_bus.master),
		.sci_bus   (sci_bus.master)
	);

	dps_timer timer_i (
		.clock (clock),
		.rst   (rst),
		.bus   (timer_bus.slave),
		.match (timer_match)
	);

	dps_sci sci_i (
		.clock    (clock),
		.rst      (rst),
		.rxd      (sci_rxd),
		.bus      (sci_bus.slave),
		.txd      (sci_txd),
		.rx_event (sci_rx_event)
	);

	dps_irq_ctrl irq_ctrl_i (
		.clock     (clock),
		.rst       (rst),
		.cfg_req   (irq_cfg_req),
		.cfg_entry (irq_cfg_entry),
		.cfg_valid (irq_cfg_valid),
		.cfg_mask  (irq_cfg_mask),
		.cfg_level (irq_cfg_level),
		.events    (irq_events),
		.ack       (irq_ack),
		.irq_req   (irq_req),
		.irq_num   (irq_num)
	);

endmodule

// ==== bench/dps_sva.sv ====
module dps_sva (
	input logic                clock,
	input logic                rst,
	input logic                req,
	input logic                busy,
	input logic                valid,
	input dps_pkg::bus_state_t bus_state,
	input logic                irq_req,
	input logic [5:0]          irq_num,
	input logic                ack,
	input logic [63:0]         enabled
);

	// Read response only in RESPOND, three cycles after the accepted request
	valid_in_respond: assert property (@(posedge clock) disable iff (rst)
		valid |-> (bus_state == dps_pkg::BUS_RESPOND) && $past(req && !busy, 3))
		else $error("valid seen outside the RESPOND state of an accepted request");

	// Busy covers exactly the two cycles after acceptance
	busy_two_cycles: assert property (@(posedge clock) disable iff (rst)
		busy == ($past(req && !busy) || $past(req && !busy, 2)))
		else $error("busy does not span exactly two cycles after acceptance");

	// Request and number held until acknowledge
	irq_held: assert property (@(posedge clock) disable iff (rst)
		(irq_req && !ack) |=> (irq_req && $stable(irq_num)))
		else $error("interrupt request dropped or changed before acknowledge");

	// Only enabled entries get requested
	irq_enabled: assert property (@(posedge clock) disable iff (rst)
		irq_req |-> enabled[irq_num])
		else $error("interrupt requested for a disabled entry");

endmodule

// Bus side with the interrupt inputs held quiet
bind dps_bus_ctrl dps_sva bus_sva_i (
	.clock     (clock),
	.rst       (rst),
	.req       (req),
	.busy      (busy),
	.valid     (valid),
	.bus_state (state),
	.irq_req   (1'b0),
	.irq_num   (6'd0),
	.ack       (1'b0),
	.enabled   ({64{1'b1}})
);

// Interrupt side with the bus inputs held idle
bind dps_irq_ctrl dps_sva irq_sva_i (
	.clock     (clock),
	.rst       (rst),
	.req       (1'b0),
	.busy      (1'b0),
	.valid     (1'b0),
	.bus_state (dps_pkg::BUS_IDLE),
	.irq_req   (irq_req),
	.irq_num   (irq_num),
	.ack       (ack),
	.enabled   (enabled)
);

// ==== bench/tb_dps.sv ====
module tb_dps;

	// Twice the length of eight UART frames, ten slow timer periods and bus traffic
	localparam int FRAME_CYCLES = 10 * dps_pkg::BAUD_DIV;
	localparam int CMP_MAX      = 40;
	localparam int LIMIT        = 2 * (8 * FRAME_CYCLES + 10 * (CMP_MAX + 1) + 800);

	logic        clock;
	logic        rst;
	logic        irq_cfg_req;
	logic [5:0]  irq_cfg_entry;
	logic        irq_cfg_valid;
	logic        irq_cfg_mask;
	logic [1:0]  irq_cfg_level;
	logic        req;
	logic        rw;
	logic [31:0] addr;
	logic [31:0] wdata;
	logic        busy;
	logic        valid;
	logic [31:0] rdata;
	logic        irq_req;
	logic [5:0]  irq_num;
	logic        irq_ack;
	// UART loopback line
	logic        sci_line;

	int errors;
	int checks;
	int cycles = 0;

	default_peripheral_system dut_i (
		.clock         (clock),
		.rst           (rst),
		.irq_cfg_req   (irq_cfg_req),
		.irq_cfg_entry (irq_cfg_entry),
		.irq_cfg_valid (irq_cfg_valid),
		.irq_cfg_mask  (irq_cfg_mask),
		.irq_cfg_level (irq_cfg_level),
		.req           (req),
		.rw            (rw),
		.addr          (addr),
		.wdata         (wdata),
		.busy          (busy),
		.valid         (valid),
		.rdata         (rdata),
		.irq_req       (irq_req),
		.irq_num       (irq_num),
		.irq_ack       (irq_ack),
		.sci_txd       (sci_line),
		.sci_rxd       (sci_line)
	);

	always #5 clock = ~clock;

	// Watchdog
	always @(posedge clock) begin
		cycles = cycles + 1;
		if (cycles > LIMIT) begin
			$display("Error: simulation ran past %0d cycles without finishing", LIMIT);
			$display("Result: FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] reg_addr(input logic [31:0] base, input logic [3:0] offset);
		return base | {28'b0, offset};
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("Mismatch %s got 0x%08h expected 0x%08h", name, got, expected);
		end
	endtask

	task automatic report(input string what);
		errors++;
		$display("Error: %s", what);
	endtask

	// One-cycle table write
	task automatic cfg_write(input logic [5:0] entry, input logic v, input logic m,
			input logic [1:0] level);
		@(negedge clock);
		irq_cfg_req   = 1'b1;
		irq_cfg_entry = entry;
		irq_cfg_valid = v;
		irq_cfg_mask  = m;
		irq_cfg_level = level;
		@(negedge clock);
		irq_cfg_req = 1'b0;
	endtask

	task automatic bus_write(input logic [31:0] a, input logic [31:0] d);
		@(negedge clock);
		req   = 1'b1;
		rw    = 1'b1;
		addr  = a;
		wdata = d;
		@(negedge clock);
		req = 1'b0;
		while (busy) begin
			@(negedge clock);
		end
	endtask

	task automatic bus_read(input logic [31:0] a, output logic [31:0] d);
		int n;
		@(negedge clock);
		req  = 1'b1;
		rw   = 1'b0;
		addr = a;
		@(negedge clock);
		req = 1'b0;
		n   = 0;
		while (!valid && n < 8) begin
			@(negedge clock);
			n++;
		end
		if (valid) begin
			d = rdata;
		end else begin
			report($sformatf("no read response for address 0x%08h", a));
			d = '0;
		end
	endtask

	// Poll UART status until the masked bits match
	task automatic poll_stat(input logic [31:0] bit_mask, input logic [31:0] want,
			input string what);
		logic [31:0] stat;
		int          polls;
		polls = 0;
		bus_read(reg_addr(dps_pkg::SCI_BASE, dps_pkg::SCI_STAT), stat);
		while ((stat & bit_mask) != want && polls < FRAME_CYCLES / 2) begin
			bus_read(reg_addr(dps_pkg::SCI_BASE, dps_pkg::SCI_STAT), stat);
			polls++;
		end
		if ((stat & bit_mask) != want) begin
			report($sformatf("UART status never showed %s", what));
		end
	endtask

	task automatic wait_irq(input int limit, output logic seen, output logic [5:0] num);
		int n;
		n    = 0;
		seen = 1'b0;
		num  = '0;
		while (!seen && n < limit) begin
			@(negedge clock);
			if (irq_req) begin
				seen = 1'b1;
				num  = irq_num;
			end
			n++;
		end
	endtask

	// Ack at the next rising edge
	task automatic ack_irq();
		irq_ack = 1'b1;
		@(negedge clock);
		irq_ack = 1'b0;
	endtask

	task automatic take_irq(input string name, input logic [5:0] expected, input logic do_ack);
		logic       seen;
		logic [5:0] num;
		wait_irq(2 * FRAME_CYCLES, seen, num);
		if (!seen) begin
			report($sformatf("no interrupt request for %s", name));
		end else begin
			check(name, 32'(num), 32'(expected));
			if (do_ack) begin
				ack_irq();
			end
		end
	endtask

	// Clear leftover requests
	task automatic drain_irq(input int n);
		repeat (n) begin
			@(negedge clock);
			irq_ack = irq_req;
		end
		irq_ack = 1'b0;
	endtask

	task automatic send_byte(input logic [7:0] b);
		poll_stat(32'h1, 32'h0, "transmitter idle");
		bus_write(reg_addr(dps_pkg::SCI_BASE, dps_pkg::SCI_TXD), {24'b0, b});
		poll_stat(32'h2, 32'h2, "receive full");
	endtask

	// Read clears rx full
	task automatic receive_check(input logic [7:0] b);
		logic [31:0] d;
		bus_read(reg_addr(dps_pkg::SCI_BASE, dps_pkg::SCI_RXD), d);
		check("sci_rxd", d, {24'b0, b});
		bus_read(reg_addr(dps_pkg::SCI_BASE, dps_pkg::SCI_STAT), d);
		check("rx_full", d & 32'h2, 32'h0);
	endtask

	task automatic reset_and_readback();
		logic [31:0] v;
		logic [31:0] d;
		check("busy", 32'(busy), 32'h0);
		check("valid", 32'(valid), 32'h0);
		check("irq_req", 32'(irq_req), 32'h0);
		check("sci_txd", 32'(sci_line), 32'h1);
		bus_read(32'h0000_0200, d);
		check("unmapped_rdata", d, 32'h0);
		v = $urandom;
		bus_write(reg_addr(dps_pkg::TIMER_BASE, dps_pkg::TIMER_CMP), v);
		bus_read(reg_addr(dps_pkg::TIMER_BASE, dps_pkg::TIMER_CMP), d);
		check("timer_cmp", d, v);
		v = $urandom;
		bus_write(reg_addr(dps_pkg::SCI_BASE, dps_pkg::SCI_CFG), v);
		bus_read(reg_addr(dps_pkg::SCI_BASE, dps_pkg::SCI_CFG), d);
		check("sci_cfg", d, v);
		bus_write(reg_addr(dps_pkg::SCI_BASE, dps_pkg::SCI_CFG), 32'h0);
	endtask

	task automatic busy_window();
		int valid_count;
		valid_count = 0;
		@(negedge clock);
		req  = 1'b1;
		rw   = 1'b0;
		addr = reg_addr(dps_pkg::TIMER_BASE, dps_pkg::TIMER_CMP);
		// Request stays up through the first busy cycle only
		for (int i = 0; i < 6; i++) begin
			@(negedge clock);
			if (i == 1) begin
				req = 1'b0;
			end
			check($sformatf("busy cycle %0d", i), 32'(busy), 32'(i < 2));
			check($sformatf("valid cycle %0d", i), 32'(valid), 32'(i == 2));
			if (valid) begin
				valid_count++;
			end
		end
		check("valid count", 32'(valid_count), 32'h1);
	endtask

	task automatic timer_modes();
		logic [31:0] c;
		logic [31:0] d;
		logic        seen;
		logic [5:0]  num;
		c = 32'd20 + ($urandom % 32'd20);
		cfg_write(dps_pkg::IRQ_NUM_TIMER, 1'b1, 1'b1, 2'd1);
		bus_write(reg_addr(dps_pkg::TIMER_BASE, dps_pkg::TIMER_CMP), c);
		// Periodic with interrupt
		bus_write(reg_addr(dps_pkg::TIMER_BASE, dps_pkg::TIMER_MODE), 32'h3);
		bus_write(reg_addr(dps_pkg::TIMER_BASE, dps_pkg::TIMER_CTRL), 32'h1);
		take_irq("timer irq_num", dps_pkg::IRQ_NUM_TIMER, 1'b1);
		repeat (4) begin
			bus_read(reg_addr(dps_pkg::TIMER_BASE, dps_pkg::TIMER_COUNT), d);
			check("timer_count at most cmp", 32'(d <= c), 32'h1);
		end
		take_irq("timer repeat irq_num", dps_pkg::IRQ_NUM_TIMER, 1'b1);
		bus_write(reg_addr(dps_pkg::TIMER_BASE, dps_pkg::TIMER_CTRL), 32'h0);
		drain_irq(8);
		// One-shot
		bus_write(reg_addr(dps_pkg::TIMER_BASE, dps_pkg::TIMER_MODE), 32'h1);
		bus_write(reg_addr(dps_pkg::TIMER_BASE, dps_pkg::TIMER_CTRL), 32'h1);
		take_irq("oneshot irq_num", dps_pkg::IRQ_NUM_TIMER, 1'b1);
		wait_irq(int'(3 * (c + 32'd1)), seen, num);
		check("oneshot extra irq_req", 32'(seen), 32'h0);
		bus_read(reg_addr(dps_pkg::TIMER_BASE, dps_pkg::TIMER_CTRL), d);
		check("timer run", d, 32'h0);
	endtask

	task automatic uart_loopback();
		logic [7:0] b;
		logic       seen;
		logic [5:0] num;
		cfg_write(dps_pkg::IRQ_NUM_SCI_RX, 1'b1, 1'b1, 2'd1);
		// Enable plus receive interrupt
		bus_write(reg_addr(dps_pkg::SCI_BASE, dps_pkg::SCI_CFG), 32'h3);
		for (int i = 0; i < 4; i++) begin
			b = 8'($urandom);
			send_byte(b);
			receive_check(b);
			take_irq("rx irq_num", dps_pkg::IRQ_NUM_SCI_RX, 1'b1);
		end
		cfg_write(dps_pkg::IRQ_NUM_SCI_RX, 1'b1, 1'b0, 2'd1);
		b = 8'($urandom);
		send_byte(b);
		receive_check(b);
		wait_irq(20, seen, num);
		check("masked rx irq_req", 32'(seen), 32'h0);
		// Pending bit kept while masked
		cfg_write(dps_pkg::IRQ_NUM_SCI_RX, 1'b1, 1'b1, 2'd1);
		take_irq("kept rx irq_num", dps_pkg::IRQ_NUM_SCI_RX, 1'b1);
	endtask

	// Held timer request blocks the choice until both sources are pending
	task automatic priority_round(input logic [5:0] first, input logic [5:0] second);
		logic [7:0] b;
		// Compare of zero matches every cycle
		bus_write(reg_addr(dps_pkg::TIMER_BASE, dps_pkg::TIMER_CMP), 32'h0);
		bus_write(reg_addr(dps_pkg::TIMER_BASE, dps_pkg::TIMER_MODE), 32'h3);
		bus_write(reg_addr(dps_pkg::TIMER_BASE, dps_pkg::TIMER_CTRL), 32'h1);
		take_irq("blocking irq_num", dps_pkg::IRQ_NUM_TIMER, 1'b0);
		b = 8'($urandom);
		send_byte(b);
		receive_check(b);
		ack_irq();
		take_irq("first irq_num", first, 1'b0);
		// Last match lands two cycles after the stop
		bus_write(reg_addr(dps_pkg::TIMER_BASE, dps_pkg::TIMER_CTRL), 32'h0);
		repeat (2) begin
			@(negedge clock);
		end
		ack_irq();
		take_irq("second irq_num", second, 1'b1);
		drain_irq(8);
	endtask

	task automatic irq_priority();
		cfg_write(dps_pkg::IRQ_NUM_TIMER, 1'b1, 1'b1, 2'd1);
		cfg_write(dps_pkg::IRQ_NUM_SCI_RX, 1'b1, 1'b1, 2'd3);
		priority_round(dps_pkg::IRQ_NUM_SCI_RX, dps_pkg::IRQ_NUM_TIMER);
		// Equal levels serve the lower number first
		cfg_write(dps_pkg::IRQ_NUM_SCI_RX, 1'b1, 1'b1, 2'd1);
		priority_round(dps_pkg::IRQ_NUM_TIMER, dps_pkg::IRQ_NUM_SCI_RX);
	endtask

	initial begin
		void'($urandom(72465));
		errors        = 0;
		checks        = 0;
		clock         = 1'b0;
		rst           = 1'b1;
		irq_cfg_req   = 1'b0;
		irq_cfg_entry = 6'd0;
		irq_cfg_valid = 1'b0;
		irq_cfg_mask  = 1'b0;
		irq_cfg_level = 2'd0;
		req           = 1'b0;
		rw            = 1'b0;
		addr          = 32'h0;
		wdata         = 32'h0;
		irq_ack       = 1'b0;
		repeat (3) begin
			@(posedge clock);
		end
		@(negedge clock);
		rst = 1'b0;
		reset_and_readback();
		busy_window();
		timer_modes();
		uart_loopback();
		irq_priority();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
hdl/dps_pkg.sv
hdl/dps_reg_if.sv
hdl/dps_bus_ctrl.sv
hdl/dps_timer.sv
hdl/dps_sci.sv
hdl/dps_irq_ctrl.sv
hdl/default_peripheral_system.sv
bench/dps_sva.sv
bench/tb_dps.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_dps -f compile.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_dps > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

# Verdict comes from the log
if grep -q "Result: FAILED" "$LOG"; then
	exit 1
fi
exit 0
